// ==== design/dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// ************************************************************************
// Dispatch group and issue port
// ************************************************************************

// Micro-ops per dispatch group.
`define FETCH_WIDTH 2

// Oldest entries offered per queue and issue lanes.
`define OUT_WIDTH 2

// ************************************************************************
// Queues
// ************************************************************************

`define QUEUE_DEPTH 8       // Power of two, pointers wrap.
`define NUM_QUEUES  3       // One per micro-op class.

// ************************************************************************
// Index widths
// ************************************************************************

`define ROB_WIDTH  4        // Plus one direction bit.
`define PREG_WIDTH 6

`endif

// ==== design/rob_pkg.sv ====
`include "dispatch_defs.svh"

package rob_pkg;

    // Direction bit flips each time the ROB index wraps.
    typedef struct packed {
        logic                  dir;
        logic [`ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;     // Mispredicted instruction.
    } redirect_t;

    // True when entry is strictly older than the redirect point.
    function automatic logic rob_older(input rob_idx_t entry, input rob_idx_t redir);
        logic greater;
        greater = redir.idx > entry.idx;
        return (entry.dir == redir.dir) ? greater : ~greater;
    endfunction

endpackage

// ==== design/uop_pkg.sv ====
`include "dispatch_defs.svh"

package uop_pkg;

    // Class value doubles as the queue number.
    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_MEM = 2'd1,
        CLASS_MUL = 2'd2
    } uop_class_e;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5,
        OP_MUL   = 3'd6,
        OP_MULH  = 3'd7
    } uop_op_e;

    // Status bundle, also the queue payload.
    typedef struct packed {
        rob_pkg::rob_idx_t      rob_idx;
        uop_op_e                op;
        uop_class_e             cls;
        logic                   we;     // Writes rd.
        logic [`PREG_WIDTH-1:0] rd;
        logic [`PREG_WIDTH-1:0] rs1;
        logic [`PREG_WIDTH-1:0] rs2;
    } dis_status_t;

endpackage

// ==== design/dispatch_queue_if.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

interface dispatch_queue_if #(
    parameter int DEPTH = `QUEUE_DEPTH
) ();
    import uop_pkg::*;

    localparam int CNT_W = $clog2(DEPTH) + 1;

    // Router side.
    logic [`FETCH_WIDTH-1:0]        en;
    dis_status_t [`FETCH_WIDTH-1:0] status;
    logic                           dis_full;   // Group stall.
    logic                           full;

    // Issue side.
    logic                           issue_full; // Low releases a pop.
    logic [`OUT_WIDTH-1:0]          en_o;
    dis_status_t [`OUT_WIDTH-1:0]   status_o;
    logic [CNT_W-1:0]               count;

    modport router (output en, status, dis_full, input full);

    modport queue (input en, status, dis_full, issue_full,
                   output full, en_o, status_o, count);

    modport issue (output issue_full, input en_o, status_o, count);

endinterface

// ==== design/dispatch_router.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch_router (
    input  logic [`FETCH_WIDTH-1:0]                 dispatch_valid_i,
    input  uop_pkg::dis_status_t [`FETCH_WIDTH-1:0] dispatch_uop_i,
    input  rob_pkg::redirect_t                      redirect_i,
    output logic                                    dispatch_ready_o,
    dispatch_queue_if.router                        qio [`NUM_QUEUES]
);
    import uop_pkg::*;

    logic [`NUM_QUEUES-1:0] queue_full;
    logic                   dis_full;

    // ************************************************************************
    // Per-queue steering
    // ************************************************************************

    for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_steer
        localparam uop_class_e QCLS = uop_class_e'(q);

        logic [`FETCH_WIDTH-1:0] steer;

        always_comb begin
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                steer[s] = dispatch_valid_i[s] && (dispatch_uop_i[s].cls == QCLS);
            end
        end

        assign qio[q].en       = steer;
        assign qio[q].status   = dispatch_uop_i;   // Every queue sees all slots.
        assign qio[q].dis_full = dis_full;
        assign queue_full[q]   = qio[q].full;
    end

    // ************************************************************************
    // Group stall
    // ************************************************************************

    // One full queue holds the whole group, so a group is never split.
    assign dis_full         = (|queue_full) | redirect_i.valid;
    assign dispatch_ready_o = ~dis_full;

endmodule

// ==== design/dispatch_queue.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch_queue #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  rob_pkg::redirect_t redirect_i,
    dispatch_queue_if.queue    qio
);
    import rob_pkg::*;
    import uop_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = ADDR_W + 1;
    localparam int ADD_W  = $clog2(`FETCH_WIDTH) + 1;

    dis_status_t       ram [DEPTH];
    logic [ADDR_W-1:0] head;
    logic [ADDR_W-1:0] tail;
    logic [CNT_W-1:0]  count;

    logic [ADD_W-1:0]  add_num;
    logic [CNT_W-1:0]  push_num;
    logic [CNT_W-1:0]  pop_num;
    logic [CNT_W:0]    fill_sum;
    logic [ADDR_W-1:0] wr_addr [`FETCH_WIDTH];

    logic [DEPTH-1:0]  occupied;
    logic [DEPTH-1:0]  older;
    logic [DEPTH-1:0]  keep;
    logic [CNT_W-1:0]  keep_num;
    logic [ADDR_W-1:0] run_end;
    logic              keep_all;
    logic              keep_none;

    // ************************************************************************
    // Write side
    // ************************************************************************

    // Prefix count of enabled slots gives each slot its position.
    always_comb begin
        logic [ADD_W-1:0] pre;
        pre = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr_addr[i] = tail + ADDR_W'(pre);
            pre        = pre + ADD_W'(qio.en[i]);
        end
        add_num = pre;
    end

    assign push_num = qio.dis_full ? '0 : CNT_W'(add_num);
    assign fill_sum = {1'b0, count} + (CNT_W+1)'(add_num);
    assign qio.full = fill_sum > (CNT_W+1)'(DEPTH);

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (qio.en[i] && !qio.dis_full) begin
                ram[wr_addr[i]] <= qio.status[i];
            end
        end
    end

    // ************************************************************************
    // Output window
    // ************************************************************************

    for (genvar i = 0; i < `OUT_WIDTH; i++) begin : g_win
        logic [ADDR_W-1:0] rd_addr;

        assign rd_addr         = head + ADDR_W'(i);
        assign qio.en_o[i]     = (count > CNT_W'(i)) & ~redirect_i.valid;
        assign qio.status_o[i] = ram[rd_addr];
    end

    assign qio.count = count;

    always_comb begin
        if (qio.issue_full || redirect_i.valid) begin
            pop_num = '0;
        end else if (count >= CNT_W'(`OUT_WIDTH)) begin
            pop_num = CNT_W'(`OUT_WIDTH);
        end else begin
            pop_num = count;
        end
    end

    // ************************************************************************
    // Redirect walk-back
    // ************************************************************************

    always_comb begin
        logic [ADDR_W-1:0] offset;
        keep_num = '0;
        run_end  = head;
        for (int p = 0; p < DEPTH; p++) begin
            offset      = ADDR_W'(p) - head;
            occupied[p] = {1'b0, offset} < count;
            older[p]    = rob_older(ram[p].rob_idx, redirect_i.rob_idx);
        end
        keep = occupied & older;
        for (int p = 0; p < DEPTH; p++) begin
            keep_num = keep_num + CNT_W'(keep[p]);
            if (keep[p] && !keep[(p + 1) % DEPTH]) begin
                run_end = ADDR_W'(p);     // Youngest surviving entry.
            end
        end
    end

    assign keep_all  = &keep;
    assign keep_none = ~|keep;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (redirect_i.valid) begin
            tail  <= (keep_all || keep_none) ? head : run_end + ADDR_W'(1);
            count <= keep_num;
        end else begin
            head  <= head + ADDR_W'(pop_num);
            tail  <= tail + ADDR_W'(push_num);
            count <= count + push_num - pop_num;
        end
    end

endmodule

// ==== design/issue_select.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module issue_select (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  issue_stall_i,
    input  rob_pkg::redirect_t                    redirect_i,
    dispatch_queue_if.issue                       qio [`NUM_QUEUES],
    output logic [`OUT_WIDTH-1:0]                 issue_valid_o,
    output uop_pkg::dis_status_t [`OUT_WIDTH-1:0] issue_uop_o
);
    import uop_pkg::*;

    localparam int PTR_W = $clog2(`NUM_QUEUES);

    logic [`NUM_QUEUES-1:0]       nonempty;
    logic [`OUT_WIDTH-1:0]        win_en  [`NUM_QUEUES];
    dis_status_t [`OUT_WIDTH-1:0] win_uop [`NUM_QUEUES];

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] grant_idx;
    logic [PTR_W-1:0] next_ptr;
    logic             grant_valid;
    logic             grant_ok;

    for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_queue
        assign nonempty[q]       = qio[q].count != '0;
        assign win_en[q]         = qio[q].en_o;
        assign win_uop[q]        = qio[q].status_o;
        assign qio[q].issue_full = ~(grant_ok && (grant_idx == PTR_W'(q)));
    end

    // ************************************************************************
    // Round-robin grant
    // ************************************************************************

    // Walk down so the nearest queue past the pointer wins.
    always_comb begin
        int q;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = `NUM_QUEUES - 1; k >= 0; k--) begin
            q = (int'(rr_ptr) + k) % `NUM_QUEUES;
            if (nonempty[q]) begin
                grant_valid = 1'b1;
                grant_idx   = PTR_W'(q);
            end
        end
    end

    assign grant_ok = grant_valid & ~issue_stall_i & ~redirect_i.valid;
    assign next_ptr = (grant_idx == PTR_W'(`NUM_QUEUES - 1)) ? '0 : grant_idx + PTR_W'(1);

    // ************************************************************************
    // Issue port
    // ************************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_ptr        <= '0;
            issue_valid_o <= '0;
        end else if (grant_ok) begin
            rr_ptr        <= next_ptr;
            issue_valid_o <= win_en[grant_idx];
        end else begin
            issue_valid_o <= '0;          // No grant, empty port.
        end
    end

    always_ff @(posedge clk) begin
        if (grant_ok) begin
            issue_uop_o <= win_uop[grant_idx];
        end
    end

endmodule

// ==== design/dispatch_stage.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch_stage (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [`FETCH_WIDTH-1:0]                 dispatch_valid_i,
    input  uop_pkg::dis_status_t [`FETCH_WIDTH-1:0] dispatch_uop_i,
    output logic                                    dispatch_ready_o,
    input  logic                                    redirect_valid_i,
    input  rob_pkg::rob_idx_t                       redirect_rob_idx_i,
    input  logic                                    issue_stall_i,
    output logic [`OUT_WIDTH-1:0]                   issue_valid_o,
    output uop_pkg::dis_status_t [`OUT_WIDTH-1:0]   issue_uop_o
);
    import rob_pkg::*;

    redirect_t redirect;

    assign redirect.valid   = redirect_valid_i;
    assign redirect.rob_idx = redirect_rob_idx_i;

    // One link per class queue.
    dispatch_queue_if #(.DEPTH(`QUEUE_DEPTH)) qio [`NUM_QUEUES] ();

    dispatch_router u_router (
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .redirect_i       (redirect),
        .dispatch_ready_o (dispatch_ready_o),
        .qio              (qio)
    );

    // ************************************************************************
    // Class queues
    // ************************************************************************

    for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_queue
        dispatch_queue #(
            .DEPTH (`QUEUE_DEPTH)
        ) u_queue (
            .clk        (clk),
            .rst        (rst),
            .redirect_i (redirect),
            .qio        (qio[q])
        );
    end

    issue_select u_select (
        .clk           (clk),
        .rst           (rst),
        .issue_stall_i (issue_stall_i),
        .redirect_i    (redirect),
        .qio           (qio),
        .issue_valid_o (issue_valid_o),
        .issue_uop_o   (issue_uop_o)
    );

endmodule

// ==== test/tb_dispatch_model.svh ====
`ifndef TB_DISPATCH_MODEL_SVH
`define TB_DISPATCH_MODEL_SVH

// ****************************************************************************
// Reference FIFOs, one per class
// ****************************************************************************

dis_status_t model_uop [`NUM_QUEUES][$];
int          model_seq [`NUM_QUEUES][$];    // Program order number.

function automatic int class_occupancy(input int c);
    return model_uop[c].size();
endfunction

function automatic int total_queued();
    int n;
    n = 0;
    for (int c = 0; c < `NUM_QUEUES; c++) begin
        n += model_uop[c].size();
    end
    return n;
endfunction

// Oldest sequence number still queued, or dflt when all are empty.
function automatic int oldest_queued(input int dflt);
    int o;
    o = dflt;
    for (int c = 0; c < `NUM_QUEUES; c++) begin
        if (model_seq[c].size() > 0 && model_seq[c][0] < o) begin
            o = model_seq[c][0];
        end
    end
    return o;
endfunction

// Age rule with the direction bit.
function automatic logic age_before(input rob_idx_t e, input rob_idx_t r);
    if (e.dir == r.dir) begin
        return r.idx > e.idx;
    end
    return !(r.idx > e.idx);
endfunction

task automatic push_expected(input dis_status_t u, input int seq);
    model_uop[int'(u.cls)].push_back(u);
    model_seq[int'(u.cls)].push_back(seq);
endtask

task automatic pop_expected(input int c, output dis_status_t u);
    u = model_uop[c].pop_front();
    void'(model_seq[c].pop_front());
endtask

task automatic flush_from(input rob_idx_t r, output int n);
    n = 0;
    for (int c = 0; c < `NUM_QUEUES; c++) begin
        for (int i = model_uop[c].size() - 1; i >= 0; i--) begin
            if (!age_before(model_uop[c][i].rob_idx, r)) begin
                model_uop[c].delete(i);
                model_seq[c].delete(i);
                n++;
            end
        end
    end
endtask

`endif

// ==== test/tb_dispatch_stage.sv ====
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module tb_dispatch_stage;
    import rob_pkg::*;
    import uop_pkg::*;

    `include "tb_dispatch_model.svh"

    logic                               clk;
    logic                               rst;
    logic [`FETCH_WIDTH-1:0]            dispatch_valid;
    dis_status_t [`FETCH_WIDTH-1:0]     dispatch_uop;
    logic                               dispatch_ready;
    logic                               redirect_valid;
    rob_idx_t                           redirect_rob_idx;
    logic                               issue_stall;
    logic [`OUT_WIDTH-1:0]              issue_valid;
    dis_status_t [`OUT_WIDTH-1:0]       issue_uop;

    logic [31:0] lfsr;
    int          next_seq;
    int          pend_seq [`FETCH_WIDTH];
    int          stall_left;
    logic        stall_seen;
    logic        redir_seen;
    int          err_uop;
    int          err_ready;
    int          err_count;
    int          err_other;
    int          accepted_n;
    int          flushed_n;
    int          issued_n;
    int          waited;

    dispatch_stage dut0 (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid_i   (dispatch_valid),
        .dispatch_uop_i     (dispatch_uop),
        .dispatch_ready_o   (dispatch_ready),
        .redirect_valid_i   (redirect_valid),
        .redirect_rob_idx_i (redirect_rob_idx),
        .issue_stall_i      (issue_stall),
        .issue_valid_o      (issue_valid),
        .issue_uop_o        (issue_uop)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rob_idx_t seq_to_rob(input int seq);
        logic [4:0] b;
        b = seq[4:0];
        return b;
    endfunction

    task automatic check_uop(input dis_status_t got, input dis_status_t exp);
        if (got !== exp) begin
            err_uop++;
            $display("** Error at %0t: issued uop %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            err_ready++;
            $display("** Error at %0t: dispatch_ready %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            err_count++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    task automatic drive_inputs(input bit random_on);
        logic [31:0]                    r;
        logic [`FETCH_WIDTH-1:0]        v;
        dis_status_t [`FETCH_WIDTH-1:0] grp;
        int                             oldest;
        int                             pre;
        stall_seen = issue_stall;       // Levels seen by this edge.
        redir_seen = redirect_valid;
        if (!random_on) begin
            issue_stall    <= 1'b0;
            redirect_valid <= 1'b0;
            dispatch_valid <= '0;
            return;
        end
        if (stall_left > 0) begin
            stall_left--;
        end else begin
            r = take_bits(4);
            if (r == 0) begin
                r = take_bits(3);
                stall_left = 3 + int'(r);
            end
        end
        issue_stall <= (stall_left > 0);
        oldest = oldest_queued(next_seq);
        r = take_bits(5);
        if (r == 0 && !redirect_valid && oldest < next_seq) begin
            r = take_bits(4);
            redirect_valid   <= 1'b1;
            redirect_rob_idx <= seq_to_rob(oldest + int'(r) % (next_seq - oldest + 1));
            dispatch_valid   <= '0;
        end else begin
            redirect_valid <= 1'b0;
            r = take_bits(`FETCH_WIDTH);
            v = r[`FETCH_WIDTH-1:0];
            if (next_seq + `FETCH_WIDTH - oldest > 16) begin
                v = '0;             // Keep the age window in range.
            end
            pre = 0;
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                r = take_bits(2);
                grp[s].cls = uop_class_e'(int'(r) % `NUM_QUEUES);
                r = take_bits(3);
                grp[s].op = uop_op_e'(r[2:0]);
                r = take_bits(1);
                grp[s].we = r[0];
                r = take_bits(6);
                grp[s].rd = r[5:0];
                r = take_bits(6);
                grp[s].rs1 = r[5:0];
                r = take_bits(6);
                grp[s].rs2 = r[5:0];
                grp[s].rob_idx = seq_to_rob(next_seq + pre);
                pend_seq[s]    = next_seq + pre;
                if (v[s]) pre++;
            end
            dispatch_valid <= v;
            dispatch_uop   <= grp;
        end
    endtask

    // ************************************************************************
    // Checks at the falling edge
    // ************************************************************************

    task automatic score_cycle();
        dis_status_t exp;
        logic        exp_ready;
        int          c;
        int          n;
        int          pend [`NUM_QUEUES];
        if ((stall_seen || redir_seen) && |issue_valid) begin
            err_other++;
            $display("Issue port active at %0t while stalled or redirected", $time);
        end
        if (issue_valid[1] && !issue_valid[0]) begin
            err_other++;
            $display("Issue lane 1 valid without lane 0 at %0t", $time);
        end
        for (int l = 0; l < `OUT_WIDTH; l++) begin
            if (issue_valid[l]) begin
                issued_n++;
                c = int'(issue_uop[l].cls);
                if (c >= `NUM_QUEUES || class_occupancy(c) == 0) begin
                    err_other++;
                    $display("Micro-op issued at %0t with nothing left in the model", $time);
                end else begin
                    pop_expected(c, exp);
                    check_uop(issue_uop[l], exp);
                end
            end
        end
        for (int q = 0; q < `NUM_QUEUES; q++) pend[q] = 0;
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            if (dispatch_valid[s]) pend[int'(dispatch_uop[s].cls)]++;
        end
        exp_ready = !redirect_valid;
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            if (class_occupancy(q) + pend[q] > `QUEUE_DEPTH) exp_ready = 1'b0;
        end
        check_ready(dispatch_ready, exp_ready);
        if (redirect_valid) begin
            flush_from(redirect_rob_idx, n);
            flushed_n += n;
        end else if (exp_ready && |dispatch_valid) begin
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                if (dispatch_valid[s]) begin
                    push_expected(dispatch_uop[s], pend_seq[s]);
                    accepted_n++;
                    next_seq++;
                end
            end
        end
    endtask

    task automatic step(input bit random_on);
        @(posedge clk);
        drive_inputs(random_on);
        @(negedge clk);
        score_cycle();
    endtask

    initial begin
        rst              = 1'b1;
        dispatch_valid   = '0;
        dispatch_uop     = '0;
        redirect_valid   = 1'b0;
        redirect_rob_idx = '0;
        issue_stall      = 1'b0;
        lfsr             = 32'h675e_e1d8;
        next_seq         = 0;
        stall_left       = 0;
        stall_seen       = 1'b0;
        redir_seen       = 1'b0;
        err_uop          = 0;
        err_ready        = 0;
        err_count        = 0;
        err_other        = 0;
        accepted_n       = 0;
        flushed_n        = 0;
        issued_n         = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 600; i++) begin
            step(1'b1);
        end
        waited = 0;
        while (total_queued() > 0 && waited < 200) begin    // Drain.
            step(1'b0);
            waited++;
        end
        if (total_queued() > 0) begin
            err_other++;
            $display("Timeout: model queues still hold %0d micro-ops", total_queued());
        end else begin
            repeat (10) step(1'b0);
            check_count(issued_n, accepted_n - flushed_n, "issued micro-op count");
        end
        $display("errors: uop=%0d ready=%0d count=%0d other=%0d (accepted %0d, flushed %0d)",
                 err_uop, err_ready, err_count, err_other, accepted_n, flushed_n);
        if (err_uop + err_ready + err_count + err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
+incdir+test
design/rob_pkg.sv
design/uop_pkg.sv
design/dispatch_queue_if.sv
design/dispatch_router.sv
design/dispatch_queue.sv
design/issue_select.sv
design/dispatch_stage.sv
test/tb_dispatch_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dispatch_stage \
    -f compile.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "Simulation reported failure"
exit 1
